// ==== common/axis_i2c_pkg.sv ====
`default_nettype none

package axis_i2c_pkg;

    localparam int I2C_DATA_WIDTH  = 8;
    localparam int AXIS_DATA_WIDTH = 2 * I2C_DATA_WIDTH;

    // Read/write flag in the address byte
    localparam int   I2C_RW_BIT = 0;
    localparam logic WRITE      = 1'b0;
    localparam logic READ       = 1'b1;

    // System clocks per quarter SCL period
    localparam int SCL_QUARTER = 4;
    localparam int QCNT_WIDTH  = $clog2(SCL_QUARTER);

    // Bit counter within a byte
    localparam int CNT_WIDTH = 3;

    typedef enum logic [1:0] {
        CMD_START,
        CMD_STOP,
        CMD_WRITE,
        CMD_READ
    } bit_cmd_e;

    typedef enum logic [2:0] {
        IDLE,
        START,
        ADDR,
        ACK_ADDR,
        DATA,
        ACK_DATA,
        STOP,
        RESULT
    } seq_state_e;

endpackage

`default_nettype wire

// ==== common/axis_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface axis_if;
    import axis_i2c_pkg::*;

    logic [AXIS_DATA_WIDTH-1:0] tdata;
    logic                       tvalid;
    logic                       tready;

    modport master (
        output tdata,
        output tvalid,
        input  tready
    );

    modport slave (
        input  tdata,
        input  tvalid,
        output tready
    );

endinterface

`default_nettype wire

// ==== common/i2c_bit_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface i2c_bit_if;
    import axis_i2c_pkg::*;

    bit_cmd_e cmd;
    logic     cmd_valid;
    logic     tx_bit;
    logic     cmd_ready;
    logic     rx_bit;
    logic     done;

    // Sequencer side
    modport seq (
        output cmd, cmd_valid, tx_bit,
        input  cmd_ready, rx_bit, done
    );

    // Bit engine side
    modport eng (
        input  cmd, cmd_valid, tx_bit,
        output cmd_ready, rx_bit, done
    );

endinterface

`default_nettype wire

// ==== i2c_master/i2c_bit_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

module i2c_bit_engine (
    input  logic      clk_i,
    input  logic      arstn_i,
    i2c_bit_if.eng    bit_if,
    output logic      scl_o,
    output logic      sda_o,
    output logic      sda_oe_o,
    input  logic      sda_i
);
    import axis_i2c_pkg::*;

    logic                  busy;
    logic [QCNT_WIDTH-1:0] qcnt;
    logic [1:0]            phase;
    logic                  quarter_end;
    bit_cmd_e              cmd_q;
    logic                  tx_q;
    logic                  rx_q;
    logic                  scl_q;
    logic                  sda_q;
    logic                  scl_nxt;
    logic                  sda_nxt;

    assign quarter_end = (qcnt == QCNT_WIDTH'(SCL_QUARTER - 1));

    assign bit_if.cmd_ready = ~busy;
    assign bit_if.done      = busy & quarter_end & (phase == 2'd3);
    assign bit_if.rx_bit    = rx_q;

    // Four phases of SCL_QUARTER clocks per command
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (~arstn_i) begin
            busy  <= 1'b0;
            qcnt  <= '0;
            phase <= '0;
        end else if (~busy) begin
            if (bit_if.cmd_valid) begin
                busy  <= 1'b1;
                qcnt  <= '0;
                phase <= '0;
            end
        end else if (quarter_end) begin
            qcnt  <= '0;
            phase <= phase + 2'd1;
            if (phase == 2'd3) begin
                busy <= 1'b0;
            end
        end else begin
            qcnt <= qcnt + QCNT_WIDTH'(1);
        end
    end

    always_ff @(posedge clk_i) begin
        if (~busy && bit_if.cmd_valid) begin
            cmd_q <= bit_if.cmd;
            tx_q  <= bit_if.tx_bit;
        end
        // Sample in the middle of SCL high
        if (busy && (cmd_q == CMD_READ) && (phase == 2'd2) && (qcnt == '0)) begin
            rx_q <= sda_i;
        end
    end

    // Line levels for the current phase
    always_comb begin
        scl_nxt = scl_q;
        sda_nxt = sda_q;
        case (cmd_q)
            CMD_START: begin
                scl_nxt = (phase != 2'd3);
                sda_nxt = (phase < 2'd2);
            end
            CMD_STOP: begin
                scl_nxt = (phase != 2'd0);
                sda_nxt = (phase >= 2'd2);
            end
            CMD_WRITE: begin
                scl_nxt = (phase == 2'd1) || (phase == 2'd2);
                sda_nxt = tx_q;
            end
            CMD_READ: begin
                scl_nxt = (phase == 2'd1) || (phase == 2'd2);
                sda_nxt = 1'b1;
            end
            default: ;
        endcase
    end

    // Levels hold between commands
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (~arstn_i) begin
            scl_q <= 1'b1;
            sda_q <= 1'b1;
        end else if (busy) begin
            scl_q <= scl_nxt;
            sda_q <= sda_nxt;
        end
    end

    // Only a low level is driven on SDA
    assign scl_o    = scl_q;
    assign sda_o    = sda_q;
    assign sda_oe_o = ~sda_q;

endmodule

`default_nettype wire

// ==== i2c_master/i2c_transfer_seq.sv ====
`timescale 1ns/1ns
`default_nettype none

module i2c_transfer_seq (
    input  logic                                  clk_i,
    input  logic                                  arstn_i,
    axis_if.slave                                 s_axis,
    i2c_bit_if.seq                                bit_if,
    output logic [axis_i2c_pkg::I2C_DATA_WIDTH-1:0] res_data_o,
    output logic                                  res_nack_o,
    output logic                                  res_valid_o,
    input  logic                                  res_ready_i
);
    import axis_i2c_pkg::*;

    seq_state_e                state;
    logic                      issued;
    logic [CNT_WIDTH-1:0]      cnt;
    logic [I2C_DATA_WIDTH-1:0] addr_q;
    logic [I2C_DATA_WIDTH-1:0] data_q;
    logic [I2C_DATA_WIDTH-1:0] rd_q;
    logic                      nack_q;
    logic                      accept;
    logic                      is_read;

    assign s_axis.tready = (state == IDLE);
    assign accept        = s_axis.tvalid & s_axis.tready;
    assign is_read       = (addr_q[I2C_RW_BIT] == READ);

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (~arstn_i) begin
            state  <= IDLE;
            issued <= 1'b0;
            cnt    <= '0;
        end else begin
            // One bit command outstanding at a time
            if (bit_if.cmd_valid && bit_if.cmd_ready) begin
                issued <= 1'b1;
            end else if (bit_if.done) begin
                issued <= 1'b0;
            end

            case (state)
                IDLE: begin
                    if (accept) state <= START;
                end
                START: begin
                    if (bit_if.done) begin
                        state <= ADDR;
                        cnt   <= CNT_WIDTH'(I2C_DATA_WIDTH - 1);
                    end
                end
                ADDR: begin
                    if (bit_if.done) begin
                        if (cnt == '0) state <= ACK_ADDR;
                        else           cnt   <= cnt - CNT_WIDTH'(1);
                    end
                end
                ACK_ADDR: begin
                    if (bit_if.done) begin
                        // Skip the data phase on address NACK
                        if (bit_if.rx_bit) begin
                            state <= STOP;
                        end else begin
                            state <= DATA;
                            cnt   <= CNT_WIDTH'(I2C_DATA_WIDTH - 1);
                        end
                    end
                end
                DATA: begin
                    if (bit_if.done) begin
                        if (cnt == '0) state <= ACK_DATA;
                        else           cnt   <= cnt - CNT_WIDTH'(1);
                    end
                end
                ACK_DATA: begin
                    if (bit_if.done) state <= STOP;
                end
                STOP: begin
                    if (bit_if.done) state <= RESULT;
                end
                RESULT: begin
                    if (res_ready_i) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q <= s_axis.tdata[I2C_DATA_WIDTH-1:0];
            data_q <= s_axis.tdata[AXIS_DATA_WIDTH-1:I2C_DATA_WIDTH];
            rd_q   <= '0;
            nack_q <= 1'b0;
        end else if (bit_if.done) begin
            case (state)
                ACK_ADDR: nack_q <= bit_if.rx_bit;
                DATA: begin
                    if (is_read) rd_q <= {rd_q[I2C_DATA_WIDTH-2:0], bit_if.rx_bit};
                end
                ACK_DATA: begin
                    if (!is_read) nack_q <= bit_if.rx_bit;
                end
                default: ;
            endcase
        end
    end

    // Bit command for the current state
    always_comb begin
        bit_if.cmd_valid = ~issued;
        bit_if.cmd       = CMD_START;
        bit_if.tx_bit    = 1'b1;
        case (state)
            START:    bit_if.cmd = CMD_START;
            ADDR: begin
                bit_if.cmd    = CMD_WRITE;
                bit_if.tx_bit = addr_q[cnt];
            end
            ACK_ADDR: bit_if.cmd = CMD_READ;
            DATA: begin
                if (is_read) begin
                    bit_if.cmd = CMD_READ;
                end else begin
                    bit_if.cmd    = CMD_WRITE;
                    bit_if.tx_bit = data_q[cnt];
                end
            end
            // Master answers a read with NACK
            ACK_DATA: bit_if.cmd = is_read ? CMD_WRITE : CMD_READ;
            STOP:     bit_if.cmd = CMD_STOP;
            default:  bit_if.cmd_valid = 1'b0;
        endcase
    end

    assign res_valid_o = (state == RESULT);
    assign res_data_o  = rd_q;
    assign res_nack_o  = nack_q;

endmodule

`default_nettype wire

// ==== source/axis_i2c_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module axis_i2c_top (
    input  logic                                   clk_i,
    input  logic                                   arstn_i,
    input  logic [axis_i2c_pkg::AXIS_DATA_WIDTH-1:0] s_tdata_i,
    input  logic                                   s_tvalid_i,
    output logic                                   s_tready_o,
    output logic [axis_i2c_pkg::I2C_DATA_WIDTH-1:0]  res_data_o,
    output logic                                   res_nack_o,
    output logic                                   res_valid_o,
    input  logic                                   res_ready_i,
    output logic                                   scl_o,
    output logic                                   sda_o,
    output logic                                   sda_oe_o,
    input  logic                                   sda_i
);

    axis_if    s_axis ();
    i2c_bit_if bit_if ();

    // Command stream into the interface
    assign s_axis.tdata  = s_tdata_i;
    assign s_axis.tvalid = s_tvalid_i;
    assign s_tready_o    = s_axis.tready;

    i2c_transfer_seq u_seq (
        .clk_i       (clk_i      ),
        .arstn_i     (arstn_i    ),
        .s_axis      (s_axis     ),
        .bit_if      (bit_if     ),
        .res_data_o  (res_data_o ),
        .res_nack_o  (res_nack_o ),
        .res_valid_o (res_valid_o),
        .res_ready_i (res_ready_i)
    );

    i2c_bit_engine u_eng (
        .clk_i    (clk_i   ),
        .arstn_i  (arstn_i ),
        .bit_if   (bit_if  ),
        .scl_o    (scl_o   ),
        .sda_o    (sda_o   ),
        .sda_oe_o (sda_oe_o),
        .sda_i    (sda_i   )
    );

endmodule

`default_nettype wire

// ==== tb/i2c_target_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module i2c_target_model #(
    parameter logic [6:0] TARGET_ADDR = 7'h2A
) (
    input  logic scl_i,
    input  logic sda_i,
    output logic sda_pull_o
);
    import axis_i2c_pkg::*;

    logic [I2C_DATA_WIDTH-1:0] mem_q;
    logic [I2C_DATA_WIDTH-1:0] shift_q;
    logic                      start_seen;

    // One byte, MSB first, sampled on SCL rise
    task automatic receive_byte();
        for (int i = 0; i < I2C_DATA_WIDTH; i++) begin
            @(posedge scl_i);
            shift_q = {shift_q[I2C_DATA_WIDTH-2:0], sda_i};
        end
    endtask

    initial begin
        sda_pull_o = 1'b0;
        mem_q      = '0;
        forever begin
            // START is SDA falling while SCL is high
            start_seen = 1'b0;
            while (!start_seen) begin
                @(negedge sda_i);
                start_seen = scl_i;
            end
            receive_byte();
            if (shift_q[I2C_DATA_WIDTH-1:1] == TARGET_ADDR) begin
                @(negedge scl_i);
                sda_pull_o = 1'b1;
                @(negedge scl_i);
                if (shift_q[I2C_RW_BIT] == READ) begin
                    for (int i = I2C_DATA_WIDTH - 1; i >= 0; i--) begin
                        sda_pull_o = ~mem_q[i];
                        @(negedge scl_i);
                    end
                    // Master sends its NACK, then STOP
                    sda_pull_o = 1'b0;
                end else begin
                    sda_pull_o = 1'b0;
                    receive_byte();
                    mem_q = shift_q;
                    @(negedge scl_i);
                    sda_pull_o = 1'b1;
                    @(negedge scl_i);
                    sda_pull_o = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_checker #(
    parameter logic [6:0] TARGET_ADDR = 7'h2A
) (
    input  logic                                     clk_i,
    input  logic                                     arstn_i,
    input  logic [axis_i2c_pkg::AXIS_DATA_WIDTH-1:0] s_tdata_i,
    input  logic                                     s_tvalid_i,
    input  logic                                     s_tready_i,
    input  logic [axis_i2c_pkg::I2C_DATA_WIDTH-1:0]  res_data_i,
    input  logic                                     res_nack_i,
    input  logic                                     res_valid_i,
    input  logic                                     res_ready_i,
    output int                                       pass_cnt_o,
    output int                                       fail_cnt_o
);
    import axis_i2c_pkg::*;

    logic [AXIS_DATA_WIDTH-1:0] pending[$];
    logic [I2C_DATA_WIDTH-1:0]  reg_copy = '0;
    int                         pass_cnt = 0;
    int                         fail_cnt = 0;

    assign pass_cnt_o = pass_cnt;
    assign fail_cnt_o = fail_cnt;

    // Expected {nack, data} of one transfer
    function automatic logic [I2C_DATA_WIDTH:0] expected_result(
        input logic [AXIS_DATA_WIDTH-1:0] word,
        input logic [I2C_DATA_WIDTH-1:0]  reg_val
    );
        if (word[I2C_DATA_WIDTH-1:1] != TARGET_ADDR) begin
            return {1'b1, {I2C_DATA_WIDTH{1'b0}}};
        end
        if (word[I2C_RW_BIT] == READ) begin
            return {1'b0, reg_val};
        end
        return '0;
    endfunction

    // Sampled mid-cycle ahead of the handshake edge
    always @(negedge clk_i) begin : compare
        logic [AXIS_DATA_WIDTH-1:0] word;
        logic [I2C_DATA_WIDTH:0]    expected;
        if (arstn_i) begin
            if (res_valid_i && res_ready_i) begin
                if (pending.size() == 0) begin
                    $display("A result was delivered with no command word behind it");
                    fail_cnt++;
                end else begin
                    word     = pending.pop_front();
                    expected = expected_result(word, reg_copy);
                    if (expected !== {res_nack_i, res_data_i}) begin
                        $display("FAILED at %0t ns: word 0x%h nack %b data 0x%h, expected %b 0x%h",
                                 $time, word, res_nack_i, res_data_i,
                                 expected[I2C_DATA_WIDTH], expected[I2C_DATA_WIDTH-1:0]);
                        fail_cnt++;
                    end else begin
                        $display("ok     word 0x%h: nack %b data 0x%h",
                                 word, res_nack_i, res_data_i);
                        pass_cnt++;
                    end
                    if (!expected[I2C_DATA_WIDTH] && word[I2C_RW_BIT] == WRITE) begin
                        reg_copy = word[AXIS_DATA_WIDTH-1:I2C_DATA_WIDTH];
                    end
                end
            end
            if (s_tvalid_i && s_tready_i) begin
                if (pending.size() != 0) begin
                    $display("Command word 0x%h was accepted while a result was pending", s_tdata_i);
                    fail_cnt++;
                end
                pending.push_back(s_tdata_i);
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_axis_i2c.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_axis_i2c;
    import axis_i2c_pkg::*;

    localparam logic [6:0] TARGET_ADDR  = 7'h2A;
    localparam logic [6:0] OTHER_ADDR   = 7'h13;
    localparam int         TIMEOUT      = 1000;
    localparam int         RAND_COUNT   = 20;
    localparam int         RESULT_COUNT = 5 + RAND_COUNT;

    logic                       clk;
    logic                       arstn;
    logic [AXIS_DATA_WIDTH-1:0] s_tdata;
    logic                       s_tvalid;
    logic                       s_tready;
    logic [I2C_DATA_WIDTH-1:0]  res_data;
    logic                       res_nack;
    logic                       res_valid;
    logic                       res_ready;
    logic                       scl;
    logic                       sda_out;
    logic                       sda_oe;
    logic                       sda_pull;
    logic                       sda_line;
    logic [31:0]                rng = 32'd68602;
    int                         tb_errors = 0;
    int                         pass_cnt;
    int                         fail_cnt;

    // Line reads low when either side pulls
    assign sda_line = ~(sda_oe | sda_pull);

    axis_i2c_top axis_i2c_top_i (
        .clk_i       (clk),
        .arstn_i     (arstn),
        .s_tdata_i   (s_tdata),
        .s_tvalid_i  (s_tvalid),
        .s_tready_o  (s_tready),
        .res_data_o  (res_data),
        .res_nack_o  (res_nack),
        .res_valid_o (res_valid),
        .res_ready_i (res_ready),
        .scl_o       (scl),
        .sda_o       (sda_out),
        .sda_oe_o    (sda_oe),
        .sda_i       (sda_line)
    );

    i2c_target_model #(.TARGET_ADDR(TARGET_ADDR)) target (
        .scl_i      (scl),
        .sda_i      (sda_line),
        .sda_pull_o (sda_pull)
    );

    tb_checker #(.TARGET_ADDR(TARGET_ADDR)) result_checker (
        .clk_i       (clk),
        .arstn_i     (arstn),
        .s_tdata_i   (s_tdata),
        .s_tvalid_i  (s_tvalid),
        .s_tready_i  (s_tready),
        .res_data_i  (res_data),
        .res_nack_i  (res_nack),
        .res_valid_i (res_valid),
        .res_ready_i (res_ready),
        .pass_cnt_o  (pass_cnt),
        .fail_cnt_o  (fail_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Expects tvalid already raised on an earlier edge
    task automatic wait_accept();
        int   waited;
        logic accepted;
        waited   = 0;
        accepted = 1'b0;
        while (!accepted && waited < TIMEOUT) begin
            @(negedge clk);
            accepted = s_tready;
            @(posedge clk);
            waited++;
        end
        if (!accepted) begin
            $display("Timeout: command word 0x%h not accepted in %0d cycles", s_tdata, TIMEOUT);
            tb_errors++;
        end
    endtask

    task automatic send_word(input logic [AXIS_DATA_WIDTH-1:0] word);
        s_tdata  <= word;
        s_tvalid <= 1'b1;
        wait_accept();
        s_tvalid <= 1'b0;
    endtask

    task automatic take_result(input logic stall);
        int   waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        while (!taken && waited < TIMEOUT) begin
            rng = xorshift(rng);
            res_ready <= !stall || rng[0];
            @(negedge clk);
            taken = res_valid && res_ready;
            @(posedge clk);
            waited++;
        end
        res_ready <= 1'b0;
        if (!taken) begin
            $display("Timeout: no result was delivered in %0d cycles", TIMEOUT);
            tb_errors++;
        end
    endtask

    initial begin
        arstn     = 1'b0;
        s_tdata   = '0;
        s_tvalid  = 1'b0;
        res_ready = 1'b0;
        repeat (3) @(posedge clk);
        arstn <= 1'b1;
        @(negedge clk);
        if (s_tready !== 1'b1 || res_valid !== 1'b0 || scl !== 1'b1 || sda_out !== 1'b1 ||
            sda_oe !== 1'b0) begin
            $display("FAILED at %0t ns: outputs after reset are not idle", $time);
            tb_errors++;
        end else begin
            $display("ok     idle outputs after reset");
        end
        @(posedge clk);

        rng = xorshift(rng);
        send_word({rng[7:0], TARGET_ADDR, WRITE});
        take_result(1'b0);
        send_word({8'h00, TARGET_ADDR, READ});
        take_result(1'b0);
        // Unknown address must not touch the register
        send_word({rng[15:8], OTHER_ADDR, WRITE});
        take_result(1'b0);
        send_word({8'h00, OTHER_ADDR, READ});
        take_result(1'b0);
        send_word({8'h00, TARGET_ADDR, READ});
        take_result(1'b0);

        // Next word waits on the bus while each result is held
        rng = xorshift(rng);
        s_tdata  <= {rng[15:8], TARGET_ADDR, rng[16]};
        s_tvalid <= 1'b1;
        wait_accept();
        for (int i = 0; i < RAND_COUNT; i++) begin
            rng = xorshift(rng);
            if (i < RAND_COUNT - 1) begin
                s_tdata <= {rng[15:8], TARGET_ADDR, rng[16]};
            end else begin
                s_tvalid <= 1'b0;
            end
            take_result(1'b1);
            if (i < RAND_COUNT - 1) begin
                wait_accept();
            end
        end

        repeat (2) @(posedge clk);
        if (pass_cnt + fail_cnt != RESULT_COUNT) begin
            $display("Expected %0d results but %0d were checked", RESULT_COUNT,
                     pass_cnt + fail_cnt);
            tb_errors++;
        end
        $display("Results: %0d ok, %0d wrong, %0d other errors", pass_cnt, fail_cnt, tb_errors);
        if (fail_cnt == 0 && tb_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
common/axis_i2c_pkg.sv
common/axis_if.sv
common/i2c_bit_if.sv
i2c_master/i2c_bit_engine.sv
i2c_master/i2c_transfer_seq.sv
source/axis_i2c_top.sv
tb/i2c_target_model.sv
tb/tb_checker.sv
tb/tb_axis_i2c.sv

// ==== Makefile ====
TOP := tb_axis_i2c

all: run

run:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f filelist.f --Mdir obj_dir -o sim
	./obj_dir/sim > sim.log 2>&1 || true
	cat sim.log
	grep -qF '*** PASSED ***' sim.log

lint:
	verilator --lint-only -Wall --top-module axis_i2c_top \
		common/axis_i2c_pkg.sv common/axis_if.sv common/i2c_bit_if.sv \
		i2c_master/i2c_bit_engine.sv i2c_master/i2c_transfer_seq.sv \
		source/axis_i2c_top.sv

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
